//--- cache_pkg.sv
`default_nettype none

package cache_pkg;

	// a word address splits into a tag above a line index
	localparam int ADDR_W  = 12;
	localparam int INDEX_W = 4;
	localparam int TAG_W   = ADDR_W - INDEX_W;
	localparam int DATA_W  = 32;

	// controller states in a two-bit encoding
	typedef enum logic [1:0] {
		st_idle        = 2'd0,
		st_compare_tag = 2'd1,
		st_allocate    = 2'd2,
		st_write_back  = 2'd3
	} cache_state_t;

endpackage

`default_nettype wire

//--- l1_cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache_controller
	import cache_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         cache_cs,
	input  logic         cache_we,
	input  logic         cache_hit,
	input  logic         cache_dirty,
	input  logic         mem_ack,
	output logic         sram_cs,
	output logic         sram_we,
	output logic         stall,
	output logic         mem_cs,
	output logic         mem_we,
	output logic         mem_wb,
	output logic         fill_we,
	output logic         capture,
	output cache_state_t state
);

	logic req;
	logic hit_now;

	assign req     = cache_cs || cache_we;
	assign hit_now = (state == st_compare_tag) && cache_hit;

	// the data array is read on every request so a victim word is ready
	assign sram_cs = req;
	assign sram_we = (hit_now && cache_we) || (fill_we && mem_ack);
	assign stall   = req && !hit_now;
	assign capture = (state == st_idle) && req;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state   <= st_idle;
			mem_cs  <= 1'b0;
			mem_we  <= 1'b0;
			mem_wb  <= 1'b0;
			fill_we <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (req)
						state <= st_compare_tag;
				end

				st_compare_tag:
				begin
					if (cache_hit)
					begin
						mem_cs  <= 1'b0;
						mem_we  <= 1'b0;
						mem_wb  <= 1'b0;
						fill_we <= 1'b0;
						state   <= st_idle;
					end
					else if (cache_dirty)
					begin
						mem_cs <= 1'b1;
						mem_we <= 1'b1;
						mem_wb <= 1'b1;
						state  <= st_write_back;
					end
					else
					begin
						mem_cs  <= 1'b1;
						fill_we <= 1'b1;
						state   <= st_allocate;
					end
				end

				st_write_back:
				begin
					// mem_cs drops for one cycle so the fill is a request of its own
					if (mem_ack)
					begin
						mem_cs  <= 1'b0;
						mem_we  <= 1'b0;
						mem_wb  <= 1'b0;
						fill_we <= 1'b1;
						state   <= st_allocate;
					end
				end

				st_allocate:
				begin
					if (mem_ack)
					begin
						mem_cs  <= 1'b0;
						fill_we <= 1'b0;
						state   <= st_compare_tag;
					end
					else
					begin
						mem_cs <= 1'b1;
					end
				end

				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- cache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store
	import cache_pkg::*;
#(
	parameter int ADDR_W  = cache_pkg::ADDR_W,
	parameter int INDEX_W = cache_pkg::INDEX_W
)
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic [ADDR_W-1:0]         cpu_addr,
	input  logic                      fill_we,
	input  logic                      mem_ack,
	input  logic                      write_hit_mark,
	output logic                      cache_hit,
	output logic                      cache_dirty,
	output logic [ADDR_W-INDEX_W-1:0] victim_tag
);

	localparam int TAG_W = ADDR_W - INDEX_W;
	localparam int LINES = 2 ** INDEX_W;

	logic [LINES-1:0]   valid;
	logic [LINES-1:0]   dirty;
	logic [TAG_W-1:0]   tags [LINES];
	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   addr_tag;
	logic               fill;
	logic               mark;

	assign index    = cpu_addr[INDEX_W-1:0];
	assign addr_tag = cpu_addr[ADDR_W-1:INDEX_W];
	assign fill     = fill_we && mem_ack;
	assign mark     = write_hit_mark && !fill;

	assign victim_tag  = tags[index];
	assign cache_hit   = valid[index] && (tags[index] == addr_tag);
	assign cache_dirty = valid[index] && dirty[index];

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			valid <= '0;
			dirty <= '0;
		end
		else if (fill)
		begin
			// a refilled line matches memory again
			valid[index] <= 1'b1;
			dirty[index] <= 1'b0;
		end
		else if (mark)
		begin
			dirty[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill)
			tags[index] <= addr_tag;
	end

endmodule

`default_nettype wire

//--- cache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module cache_data_array
	import cache_pkg::*;
#(
	parameter int INDEX_W = cache_pkg::INDEX_W,
	parameter int DATA_W  = cache_pkg::DATA_W
)
(
	input  logic               clk,
	input  logic               sram_cs,
	input  logic               sram_we,
	input  logic               stall,
	input  logic [INDEX_W-1:0] index,
	input  logic [DATA_W-1:0]  wdata,
	output logic [DATA_W-1:0]  rdata,
	output logic               rdata_valid
);

	logic [DATA_W-1:0] mem [2 ** INDEX_W];

	// a write leaves the read register alone, so the victim word survives
	always_ff @(posedge clk)
	begin
		if (sram_cs)
		begin
			if (sram_we)
				mem[index] <= wdata;
			else
				rdata <= mem[index];
		end
	end

	// only the read that completes a CPU access is flagged
	always_ff @(posedge clk)
	begin
		rdata_valid <= sram_cs && !sram_we && !stall;
	end

endmodule

`default_nettype wire

//--- cache_fill_path.sv
`timescale 1ns/1ps
`default_nettype none

module cache_fill_path
	import cache_pkg::*;
#(
	parameter int ADDR_W  = cache_pkg::ADDR_W,
	parameter int INDEX_W = cache_pkg::INDEX_W,
	parameter int DATA_W  = cache_pkg::DATA_W
)
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      capture,
	input  logic                      write_back,
	input  logic                      fill_we,
	input  logic [ADDR_W-1:0]         cpu_addr,
	input  logic [DATA_W-1:0]         cpu_wdata,
	input  logic [ADDR_W-INDEX_W-1:0] victim_tag,
	input  logic [DATA_W-1:0]         mem_rdata,
	input  logic [DATA_W-1:0]         sram_rdata,
	output logic [ADDR_W-1:0]         mem_addr,
	output logic [DATA_W-1:0]         mem_wdata,
	output logic [DATA_W-1:0]         sram_wdata
);

	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wdata;

	// the request is held here while the controller works on memory
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			req_addr  <= '0;
			req_wdata <= '0;
		end
		else if (capture)
		begin
			req_addr  <= cpu_addr;
			req_wdata <= cpu_wdata;
		end
	end

	// a write-back goes to the victim line, which shares the request index
	assign mem_addr = write_back ? {victim_tag, req_addr[INDEX_W-1:0]} : req_addr;

	// the victim word was read from the data array during compare_tag
	assign mem_wdata = sram_rdata;

	assign sram_wdata = fill_we ? mem_rdata : req_wdata;

endmodule

`default_nettype wire

//--- l1_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache_top
	import cache_pkg::*;
#(
	parameter int ADDR_W  = cache_pkg::ADDR_W,
	parameter int INDEX_W = cache_pkg::INDEX_W,
	parameter int DATA_W  = cache_pkg::DATA_W
)
(
	input  logic              clk,
	input  logic              rst,
	input  logic              cache_cs,
	input  logic              cache_we,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0] cpu_wdata,
	output logic              stall,
	output logic [DATA_W-1:0] cpu_rdata,
	output logic              rdata_valid,
	output logic              mem_cs,
	output logic              mem_we,
	output logic              mem_wb,
	output logic [ADDR_W-1:0] mem_addr,
	output logic [DATA_W-1:0] mem_wdata,
	input  logic [DATA_W-1:0] mem_rdata,
	input  logic              mem_ack
);

	logic                      cache_hit;
	logic                      cache_dirty;
	logic                      sram_cs;
	logic                      sram_we;
	logic                      fill_we;
	logic                      capture;
	logic [ADDR_W-INDEX_W-1:0] victim_tag;
	logic [DATA_W-1:0]         sram_wdata;

	// kept for waveforms
	cache_state_t state;

	l1_cache_controller ctrl_i (
		.clk         (clk),
		.rst         (rst),
		.cache_cs    (cache_cs),
		.cache_we    (cache_we),
		.cache_hit   (cache_hit),
		.cache_dirty (cache_dirty),
		.mem_ack     (mem_ack),
		.sram_cs     (sram_cs),
		.sram_we     (sram_we),
		.stall       (stall),
		.mem_cs      (mem_cs),
		.mem_we      (mem_we),
		.mem_wb      (mem_wb),
		.fill_we     (fill_we),
		.capture     (capture),
		.state       (state)
	);

	cache_tag_store #(
		.ADDR_W  (ADDR_W),
		.INDEX_W (INDEX_W)
	) tags_i (
		.clk            (clk),
		.rst            (rst),
		.cpu_addr       (cpu_addr),
		.fill_we        (fill_we),
		.mem_ack        (mem_ack),
		.write_hit_mark (sram_we),
		.cache_hit      (cache_hit),
		.cache_dirty    (cache_dirty),
		.victim_tag     (victim_tag)
	);

	cache_data_array #(
		.INDEX_W (INDEX_W),
		.DATA_W  (DATA_W)
	) data_i (
		.clk         (clk),
		.sram_cs     (sram_cs),
		.sram_we     (sram_we),
		.stall       (stall),
		.index       (cpu_addr[INDEX_W-1:0]),
		.wdata       (sram_wdata),
		.rdata       (cpu_rdata),
		.rdata_valid (rdata_valid)
	);

	cache_fill_path #(
		.ADDR_W  (ADDR_W),
		.INDEX_W (INDEX_W),
		.DATA_W  (DATA_W)
	) fill_i (
		.clk        (clk),
		.rst        (rst),
		.capture    (capture),
		.write_back (mem_wb),
		.fill_we    (fill_we),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.victim_tag (victim_tag),
		.mem_rdata  (mem_rdata),
		.sram_rdata (cpu_rdata),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.sram_wdata (sram_wdata)
	);

endmodule

`default_nettype wire

//--- l1_cache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache_checker
	import cache_pkg::*;
#(
	parameter int ADDR_W = cache_pkg::ADDR_W,
	parameter int DATA_W = cache_pkg::DATA_W,
	parameter logic [DATA_W-1:0] PATTERN = '0
)
(
	input  logic              clk,
	input  logic              rst,
	input  logic              cache_cs,
	input  logic              cache_we,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0] cpu_wdata,
	input  logic              stall,
	input  logic [DATA_W-1:0] cpu_rdata,
	input  logic              rdata_valid,
	input  logic              mem_cs,
	input  logic              mem_we,
	input  logic              mem_wb,
	input  logic [ADDR_W-1:0] mem_addr,
	input  logic [DATA_W-1:0] mem_wdata,
	input  logic              mem_ack,
	input  logic [DATA_W-1:0] exp_rdata,
	input  logic              exp_hit,
	output int                errors
);

	// image of memory as the CPU sees it, the latest write wins
	logic [DATA_W-1:0] image [2 ** ADDR_W];
	logic [DATA_W-1:0] exp_img;
	logic [DATA_W-1:0] exp_tab;
	logic              pending;
	logic              mem_seen;
	logic              started;
	int                cycles;

	task automatic log_error(input string msg);
		errors++;
		$display("FAILED %0t: %s", $time, msg);
	endtask

	always @(posedge clk)
	begin
		if (!rst)
		begin
			for (int a = 0; a < 2 ** ADDR_W; a++)
				image[a] = PATTERN ^ DATA_W'(a);
			errors   = 0;
			pending  = 1'b0;
			mem_seen = 1'b0;
			started  = 1'b0;
			cycles   = 0;
		end
		else
		begin
			if (!started && (mem_cs || mem_we || mem_wb || rdata_valid || stall))
				log_error("memory controls, rdata_valid or stall not low after reset");
			started = 1'b1;
			// read data is due one cycle after the completing edge
			if (pending && !rdata_valid)
				log_error("rdata_valid missing after a completed read");
			else if (!pending && rdata_valid)
				log_error("rdata_valid without a completed read");
			else if (pending && (cpu_rdata !== exp_img || cpu_rdata !== exp_tab))
				log_error($sformatf("read data %h, image %h, table %h",
					cpu_rdata, exp_img, exp_tab));
			pending = 1'b0;
			if (mem_ack && mem_wb && mem_wdata !== image[mem_addr])
				log_error($sformatf("write-back to %h carries %h, expected %h",
					mem_addr, mem_wdata, image[mem_addr]));
			if (cache_cs || cache_we)
			begin
				cycles++;
				if (mem_cs)
					mem_seen = 1'b1;
				if (!stall)
				begin
					if (exp_hit && (cycles != 2 || mem_seen))
						log_error($sformatf("hit to %h took %0d cycles, memory used %0b",
							cpu_addr, cycles, mem_seen));
					if (cache_we)
						image[cpu_addr] = cpu_wdata;
					else
					begin
						pending = 1'b1;
						exp_img = image[cpu_addr];
						exp_tab = exp_rdata;
					end
					cycles   = 0;
					mem_seen = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- l1_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache_tb
	import cache_pkg::*;
();

	localparam logic [DATA_W-1:0] PATTERN = 32'hA5C3_96E1;
	localparam int TIMEOUT = 60;

	logic              clk = 1'b0;
	logic              rst;
	logic              cache_cs;
	logic              cache_we;
	logic [ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_wdata;
	logic              stall;
	logic [DATA_W-1:0] cpu_rdata;
	logic              rdata_valid;
	logic              mem_cs;
	logic              mem_we;
	logic              mem_wb;
	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata;
	logic [DATA_W-1:0] mem_rdata = '0;
	logic              mem_ack = 1'b0;
	logic [DATA_W-1:0] exp_rdata;
	logic              exp_hit;
	int                errors;

	// one entry per CPU access
	bit                op_we [$];
	logic [ADDR_W-1:0] op_addr [$];
	logic [DATA_W-1:0] op_wdata [$];
	logic [DATA_W-1:0] op_exp [$];
	bit                op_hit [$];

	logic [DATA_W-1:0] memory [2 ** ADDR_W];
	int                delay;
	bit                answered;

	l1_cache_top #(
		.ADDR_W  (ADDR_W),
		.INDEX_W (INDEX_W),
		.DATA_W  (DATA_W)
	) dut_i (.*);

	l1_cache_checker #(
		.ADDR_W  (ADDR_W),
		.DATA_W  (DATA_W),
		.PATTERN (PATTERN)
	) check_i (.*);

	always #20 clk = ~clk;

	function automatic logic [DATA_W-1:0] initial_word(input logic [ADDR_W-1:0] addr);
		return PATTERN ^ DATA_W'(addr);
	endfunction

	task automatic add_op(input bit we, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] expect_data, input bit hit);
		op_we.push_back(we);
		op_addr.push_back(addr);
		op_wdata.push_back(wdata);
		op_exp.push_back(expect_data);
		op_hit.push_back(hit);
	endtask

	// the access completes at the rising edge after stall is seen low
	task automatic wait_for_completion(output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < TIMEOUT && !ok; n++)
		begin
			@(negedge clk);
			if (!stall)
				ok = 1'b1;
		end
	endtask

	// memory answers each mem_cs episode once, after 1 to 4 cycles
	always @(negedge clk)
	begin
		mem_ack = 1'b0;
		if (!rst)
		begin
			for (int a = 0; a < 2 ** ADDR_W; a++)
				memory[a] = initial_word(ADDR_W'(a));
			delay    = 0;
			answered = 1'b0;
		end
		else if (!mem_cs)
		begin
			delay    = 0;
			answered = 1'b0;
		end
		else if (!answered)
		begin
			if (delay == 0)
				delay = 1 + ($urandom % 4);
			delay--;
			if (delay == 0)
			begin
				mem_ack  = 1'b1;
				answered = 1'b1;
				if (mem_we)
					memory[mem_addr] = mem_wdata;
				else
					mem_rdata = memory[mem_addr];
			end
		end
	end

	initial
	begin
		int          i;
		int          failed_op;
		bit          ok;
		bit          timed_out;
		int unsigned seed_val;
		seed_val  = $urandom(76);
		rst       = 1'b0;
		cache_cs  = 1'b0;
		cache_we  = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		exp_rdata = '0;
		exp_hit   = 1'b0;
		timed_out = 1'b0;
		failed_op = 0;
		add_op(0, 12'h013, '0, initial_word(12'h013), 0);
		add_op(0, 12'h013, '0, initial_word(12'h013), 1);
		add_op(1, 12'h025, 32'hDEAD_BEEF, '0, 0);
		add_op(0, 12'h025, '0, 32'hDEAD_BEEF, 1);
		add_op(1, 12'h025, 32'h1234_5678, '0, 1);
		// same index as 025, so the dirty line goes back to memory first
		add_op(0, 12'h135, '0, initial_word(12'h135), 0);
		add_op(0, 12'h025, '0, 32'h1234_5678, 0);
		add_op(1, 12'h3F0, 32'hCAFE_F00D, '0, 0);
		add_op(1, 12'h7F0, 32'h0BAD_C0DE, '0, 0);
		add_op(0, 12'h3F0, '0, 32'hCAFE_F00D, 0);
		add_op(0, 12'h7F0, '0, 32'h0BAD_C0DE, 0);
		add_op(0, 12'h013, '0, initial_word(12'h013), 1);
		add_op(0, 12'hFFF, '0, initial_word(12'hFFF), 0);
		repeat (5) @(negedge clk);
		rst = 1'b1;
		for (i = 0; i < op_addr.size() && !timed_out; i++)
		begin
			@(negedge clk);
			cache_cs  = !op_we[i];
			cache_we  = op_we[i];
			cpu_addr  = op_addr[i];
			cpu_wdata = op_wdata[i];
			exp_rdata = op_exp[i];
			exp_hit   = op_hit[i];
			wait_for_completion(ok);
			if (!ok)
			begin
				timed_out = 1'b1;
				failed_op = i;
			end
		end
		@(negedge clk);
		cache_cs = 1'b0;
		cache_we = 1'b0;
		repeat (3) @(negedge clk);
		$display("errors: %0d", errors);
		if (!timed_out && errors == 0)
			$display("Simulation completed successfully");
		else
		begin
			if (timed_out)
				$display("stall stayed high too long at operation %0d", failed_op);
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- l1_cache_top.f
cache_pkg.sv
l1_cache_controller.sv
cache_tag_store.sv
cache_data_array.sv
cache_fill_path.sv
l1_cache_top.sv
l1_cache_checker.sv
l1_cache_tb.sv
